/* bench/preview_properties.sv */
`timescale 1ns/10ps

module preview_properties #(
    parameter bit LINK_SIDE = 1'b1
) (
    input logic core_clk,
    input logic sys_reset,
    input logic stall_i,
    input logic out_valid_i,
    input logic pop_i,
    input logic not_empty_i,
    input logic overflow_i
);

    if (LINK_SIDE) begin : g_link
        // a stalled link gets no byte in the following cycle
        no_byte_after_stall: assert property (
            @(posedge core_clk) disable iff (sys_reset) stall_i |=> !out_valid_i
        ) else $error("out_valid_o high in the cycle after stall_i");
    end else begin : g_buffer
        no_pop_when_empty: assert property (
            @(posedge core_clk) disable iff (sys_reset) pop_i |-> not_empty_i
        ) else $error("pop asserted while the buffer is empty");

        no_overflow: assert property (
            @(posedge core_clk) disable iff (sys_reset) !overflow_i
        ) else $error("pixel buffer overflowed");
    end

endmodule

// buffer side is unused on the serializer
bind frame_serializer preview_properties #(.LINK_SIDE(1'b1)) u_serializer_props (
    .core_clk    (core_clk),
    .sys_reset   (sys_reset),
    .stall_i     (stall_i),
    .out_valid_i (out_valid_o),
    .pop_i       (1'b0),
    .not_empty_i (1'b0),
    .overflow_i  (1'b0)
);

// link side is unused on the fifo
bind pixel_fifo preview_properties #(.LINK_SIDE(1'b0)) u_fifo_props (
    .core_clk    (core_clk),
    .sys_reset   (sys_reset),
    .stall_i     (1'b0),
    .out_valid_i (1'b0),
    .pop_i       (pop_i),
    .not_empty_i (not_empty_o),
    .overflow_i  (overflow_o)
);

/* bench/preview_tb.sv */
`timescale 1ns/10ps
`include "preview_consts.svh"

module preview_tb;
    import stream_pkg::*;

    localparam int FRAME_PIXELS = `RAW_WIDTH * `RAW_HEIGHT;
    // runs past the default corner so stray pixels reach the crop window
    localparam int PRE_PIXELS   = 100;
    localparam int NUM_FRAMES   = 14;
    // a pixel takes at most two cycles, commands get 64 cycles per frame
    localparam int INPUT_CYCLES = 2 * (NUM_FRAMES * FRAME_PIXELS + PRE_PIXELS) + 64 * NUM_FRAMES;
    localparam int CYCLE_LIMIT  = 2 * INPUT_CYCLES + 2000;

    logic        core_clk;
    logic        sys_reset;
    pixel_beat_t pixel_in;
    logic        pixel_valid;
    logic [7:0]  cmd_byte;
    logic        cmd_byte_valid;
    logic [7:0]  out_byte;
    logic        out_valid;
    logic        stall;
    logic        overflow;

    ////////////////////////////////////////////////////////////
    // reference model state

    logic [31:0] lcg_state;
    logic [63:0] magic_word;
    logic [7:0]  exp_q[$];
    logic [7:0]  cmd_q[$];
    logic [47:0] cmd_shift;
    int          cmd_count;
    int          host_col;
    int          host_row;
    int          frame_col;
    int          frame_row;
    int          next_col;
    int          next_row;
    bit          frame_open;
    int          cycle_count = 0;

    tb_clock_gen u_clock_gen (
        .core_clk_o  (core_clk),
        .sys_reset_o (sys_reset)
    );

    preview_top dut_i (
        .core_clk         (core_clk),
        .sys_reset        (sys_reset),
        .pixel_i          (pixel_in),
        .pixel_valid_i    (pixel_valid),
        .cmd_byte_i       (cmd_byte),
        .cmd_byte_valid_i (cmd_byte_valid),
        .out_byte_o       (out_byte),
        .out_valid_o      (out_valid),
        .stall_i          (stall),
        .overflow_o       (overflow)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits only, the low bits of an lcg cycle quickly
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[31:16]) % n;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0d: %s got %0h expected %0h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value check failed");
        end
    endtask

    // 6th byte of a command updates the host corner
    task automatic model_cmd_byte(input logic [7:0] b);
        logic [15:0] addr;
        logic [31:0] value;
        cmd_shift = {cmd_shift[39:0], b};
        cmd_count = cmd_count + 1;
        if (cmd_count == `CMD_BYTES) begin
            cmd_count = 0;
            addr      = cmd_shift[47:32];
            value     = cmd_shift[31:0];
            if (addr == `ADDR_COL_CORNER && value <= 32'(`RAW_WIDTH - `CROP_WIDTH)) begin
                host_col = int'(value);
            end
            if (addr == `ADDR_ROW_CORNER && value <= 32'(`RAW_HEIGHT - `CROP_HEIGHT)) begin
                host_row = int'(value);
            end
        end
    endtask

    task automatic model_pixel(input logic [7:0] data, input logic sof);
        int col;
        int row;
        int i;
        col = next_col;
        row = next_row;
        if (sof) begin
            col        = 0;
            row        = 0;
            frame_col  = host_col;
            frame_row  = host_row;
            frame_open = 1'b1;
            for (i = 0; i < 8; i++) begin
                exp_q.push_back(magic_word[63 - 8*i -: 8]);
            end
        end
        if (frame_open && col >= frame_col && col < frame_col + `CROP_WIDTH &&
            row >= frame_row && row < frame_row + `CROP_HEIGHT) begin
            exp_q.push_back(data);
        end
        next_col = (col + 1) % `RAW_WIDTH;
        next_row = (next_col == 0) ? (row + 1) % `RAW_HEIGHT : row;
    endtask

    task automatic drive_cycle(input logic valid, input logic [7:0] data, input logic sof);
        @(negedge core_clk);
        pixel_valid   = valid;
        pixel_in.data = data;
        pixel_in.sof  = sof;
        if (cmd_q.size() != 0 && rand_below(2) == 0) begin
            cmd_byte       = cmd_q.pop_front();
            cmd_byte_valid = 1'b1;
            model_cmd_byte(cmd_byte);
        end else begin
            cmd_byte       = 8'(rand_below(256));
            cmd_byte_valid = 1'b0;
        end
        stall = (rand_below(4) == 0);
    endtask

    task automatic drive_pixel(input logic sof);
        logic [7:0] data;
        // gap cycles carry junk, sof included
        if (rand_below(4) == 0) begin
            drive_cycle(1'b0, 8'(rand_below(256)), 1'(rand_below(2)));
        end
        data = 8'(rand_below(256));
        drive_cycle(1'b1, data, sof);
        model_pixel(data, sof);
    endtask

    task automatic send_frame();
        int i;
        for (i = 0; i < FRAME_PIXELS; i++) begin
            drive_pixel(i == 0);
        end
    endtask

    task automatic queue_command(input logic [15:0] addr, input logic [31:0] data);
        logic [47:0] cmd;
        int          i;
        cmd = {addr, data};
        for (i = 0; i < `CMD_BYTES; i++) begin
            cmd_q.push_back(cmd[47 - 8*i -: 8]);
        end
    endtask

    task automatic flush_commands();
        while (cmd_q.size() != 0) begin
            drive_cycle(1'b0, 8'h00, 1'b0);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // output check and timeout

    always @(negedge core_clk) begin
        if (!sys_reset && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("output byte %0h arrived while no byte was expected", out_byte);
                $display("=== FAIL ===");
                $fatal(1, "unexpected output byte");
            end else begin
                check_value("out_byte_o", 32'(out_byte), 32'(exp_q.pop_front()));
            end
        end
    end

    always @(posedge core_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int i;
        lcg_state      = 32'hdcf34f77;
        magic_word     = "BIVFRAME";
        pixel_in       = '0;
        pixel_valid    = 1'b0;
        cmd_byte       = 8'h00;
        cmd_byte_valid = 1'b0;
        stall          = 1'b0;
        cmd_shift      = '0;
        cmd_count      = 0;
        host_col       = (`RAW_WIDTH - `CROP_WIDTH) / 2;
        host_row       = (`RAW_HEIGHT - `CROP_HEIGHT) / 2;
        frame_col      = 0;
        frame_row      = 0;
        next_col       = 0;
        next_row       = 0;
        frame_open     = 1'b0;
        @(negedge core_clk);
        while (sys_reset) begin
            @(negedge core_clk);
        end

        // stray pixels ahead of the first frame start
        for (i = 0; i < PRE_PIXELS; i++) begin
            drive_pixel(1'b0);
        end
        send_frame();
        send_frame();

        // issued inside a frame, moves only the next one
        queue_command(`ADDR_COL_CORNER, 32'd0);
        send_frame();
        queue_command(`ADDR_ROW_CORNER, 32'd6);
        send_frame();

        // refused values and an unknown address
        queue_command(`ADDR_COL_CORNER, 32'd9);
        queue_command(`ADDR_ROW_CORNER, 32'd7);
        queue_command(16'h0002, 32'd1);
        queue_command(`ADDR_COL_CORNER, 32'h0001_0002);
        flush_commands();
        send_frame();
        queue_command(`ADDR_COL_CORNER, 32'd8);
        queue_command(`ADDR_ROW_CORNER, 32'd0);
        flush_commands();
        send_frame();

        // back to back frames, random corners
        for (i = 0; i < NUM_FRAMES - 6; i++) begin
            if (rand_below(2) == 0) begin
                queue_command(`ADDR_COL_CORNER, 32'(rand_below(11)));
            end
            if (rand_below(2) == 0) begin
                queue_command(`ADDR_ROW_CORNER, 32'(rand_below(9)));
            end
            if (rand_below(4) == 0) begin
                queue_command(16'(rand_below(4)), 32'(rand_below(16)));
            end
            if (rand_below(2) == 0) begin
                flush_commands();
            end
            send_frame();
        end
        flush_commands();

        while (exp_q.size() != 0) begin
            drive_cycle(1'b0, 8'h00, 1'b0);
        end
        repeat (50) drive_cycle(1'b0, 8'h00, 1'b0);
        check_value("overflow_o", 32'(overflow), 32'd0);
        check_value("expected bytes left", 32'(exp_q.size()), 32'd0);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 8
) (
    output logic core_clk_o,
    output logic sys_reset_o
);

    initial begin
        core_clk_o = 1'b0;
        forever #HALF_PERIOD core_clk_o = ~core_clk_o;
    end

    // release on a rising edge so the DUT sees a clean last reset cycle
    initial begin
        sys_reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge core_clk_o);
        sys_reset_o <= 1'b0;
    end

endmodule

/* hw/cmd_pkg.sv */
`include "preview_consts.svh"

package cmd_pkg;

    // addr sits in the upper bits so a big-endian shift
    // of the incoming bytes lines up with the fields
    typedef struct packed {
        logic [15:0] addr;
        logic [31:0] data;
    } host_cmd_t;

    // top left corner of the crop window
    typedef struct packed {
        logic [`POS_BITS-1:0] col;
        logic [`POS_BITS-1:0] row;
    } roi_corner_t;

endpackage

/* hw/crop_window.sv */
`timescale 1ns/10ps
`include "preview_consts.svh"

module crop_window (
    input  logic                      core_clk,
    input  logic                      sys_reset,
    input  stream_pkg::placed_beat_t  placed_i,
    input  logic                      placed_valid_i,
    input  cmd_pkg::roi_corner_t      corner_i,
    output logic                      push_o,
    output stream_pkg::pixel_beat_t   beat_o
);
    import stream_pkg::*;
    import cmd_pkg::*;

    localparam int POS_W = `POS_BITS;

    roi_corner_t frame_corner;
    roi_corner_t active_corner;
    logic        sof_in;
    logic        frame_seen;
    logic        in_col;
    logic        in_row;
    logic        at_corner;

    assign sof_in = placed_valid_i && placed_i.beat.sof;

    // the sof pixel already uses the corner it latches
    assign active_corner = sof_in ? corner_i : frame_corner;

    assign in_col = (placed_i.pos.col >= active_corner.col) &&
                    (placed_i.pos.col < active_corner.col + POS_W'(`CROP_WIDTH));
    assign in_row = (placed_i.pos.row >= active_corner.row) &&
                    (placed_i.pos.row < active_corner.row + POS_W'(`CROP_HEIGHT));
    assign at_corner = (placed_i.pos.col == active_corner.col) &&
                       (placed_i.pos.row == active_corner.row);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            frame_corner.col <= POS_W'(`DEFAULT_COL_CORNER);
            frame_corner.row <= POS_W'(`DEFAULT_ROW_CORNER);
            frame_seen       <= 1'b0;
            push_o           <= 1'b0;
        end else begin
            if (sof_in) begin
                frame_corner <= corner_i;
                frame_seen   <= 1'b1;
            end
            // nothing is kept until the first real frame starts
            push_o <= placed_valid_i && (frame_seen || sof_in) && in_col && in_row;
        end
    end

    always_ff @(posedge core_clk) begin
        beat_o.data <= placed_i.beat.data;
        beat_o.sof  <= at_corner;
    end

endmodule

/* hw/frame_position_counter.sv */
`timescale 1ns/10ps
`include "preview_consts.svh"

module frame_position_counter (
    input  logic                       core_clk,
    input  logic                       sys_reset,
    input  stream_pkg::pixel_beat_t    pixel_i,
    input  logic                       pixel_valid_i,
    output stream_pkg::placed_beat_t   placed_o,
    output logic                       placed_valid_o
);
    import stream_pkg::*;

    localparam int POS_W = `POS_BITS;

    // position the next valid pixel will take
    pixel_pos_t next_pos;
    pixel_pos_t cur_pos;
    pixel_pos_t adv_pos;

    always_comb begin
        // sof restarts the raster at the origin
        cur_pos = pixel_i.sof ? '0 : next_pos;
        adv_pos = cur_pos;
        if (cur_pos.col == POS_W'(`RAW_WIDTH - 1)) begin
            adv_pos.col = '0;
            if (cur_pos.row == POS_W'(`RAW_HEIGHT - 1)) begin
                adv_pos.row = '0;
            end else begin
                adv_pos.row = cur_pos.row + 1'b1;
            end
        end else begin
            adv_pos.col = cur_pos.col + 1'b1;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            next_pos       <= '0;
            placed_valid_o <= 1'b0;
        end else begin
            placed_valid_o <= pixel_valid_i;
            if (pixel_valid_i) begin
                next_pos <= adv_pos;
            end
        end
    end

    always_ff @(posedge core_clk) begin
        if (pixel_valid_i) begin
            placed_o.beat <= pixel_i;
            placed_o.pos  <= cur_pos;
        end
    end

endmodule

/* hw/frame_serializer.sv */
`timescale 1ns/10ps
`include "preview_consts.svh"

module frame_serializer (
    input  logic                     core_clk,
    input  logic                     sys_reset,
    input  stream_pkg::pixel_beat_t  head_i,
    input  logic                     not_empty_i,
    output logic                     pop_o,
    input  logic                     stall_i,
    output logic [7:0]               out_byte_o,
    output logic                     out_valid_o
);
    import stream_pkg::*;

    localparam int PIX_TOTAL   = `CROP_WIDTH * `CROP_HEIGHT;
    localparam int CNT_W       = $clog2(PIX_TOTAL);
    localparam int MAGIC_IDX_W = $clog2(`MAGIC_BYTES);

    localparam logic [`MAGIC_BYTES-1:0][7:0] MAGIC = `MAGIC_NUM;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HEADER,
        ST_PIXELS
    } ser_state_t;

    ser_state_t             state;
    logic [CNT_W-1:0]       byte_cnt;
    logic [MAGIC_IDX_W-1:0] magic_idx;
    logic                   hdr_fire;
    logic                   pix_fire;

    // msb byte of the magic number goes first
    assign magic_idx = MAGIC_IDX_W'(`MAGIC_BYTES - 1) - byte_cnt[MAGIC_IDX_W-1:0];

    assign hdr_fire = (state == ST_HEADER) && !stall_i;
    assign pix_fire = (state == ST_PIXELS) && !stall_i && not_empty_i;

    // stale pixels ahead of a frame start are thrown away
    assign pop_o = pix_fire ||
                   ((state == ST_IDLE) && not_empty_i && !head_i.sof);

    ////////////////////////////////////////////////////////////
    // state machine

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            state       <= ST_IDLE;
            byte_cnt    <= '0;
            out_valid_o <= 1'b0;
        end else begin
            out_valid_o <= hdr_fire || pix_fire;
            case (state)
                ST_IDLE: begin
                    byte_cnt <= '0;
                    if (not_empty_i && head_i.sof) begin
                        state <= ST_HEADER;
                    end
                end
                ST_HEADER: begin
                    if (hdr_fire) begin
                        if (byte_cnt == CNT_W'(`MAGIC_BYTES - 1)) begin
                            byte_cnt <= '0;
                            state    <= ST_PIXELS;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                ST_PIXELS: begin
                    if (pix_fire) begin
                        if (byte_cnt == CNT_W'(PIX_TOTAL - 1)) begin
                            byte_cnt <= '0;
                            state    <= ST_IDLE;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge core_clk) begin
        if (hdr_fire) begin
            out_byte_o <= MAGIC[magic_idx];
        end else if (pix_fire) begin
            out_byte_o <= head_i.data;
        end
    end

endmodule

/* hw/host_command_port.sv */
`timescale 1ns/10ps
`include "preview_consts.svh"

module host_command_port (
    input  logic                  core_clk,
    input  logic                  sys_reset,
    input  logic [7:0]            cmd_byte_i,
    input  logic                  cmd_byte_valid_i,
    output cmd_pkg::roi_corner_t  corner_o
);
    import cmd_pkg::*;

    localparam int POS_W = `POS_BITS;
    localparam int CNT_W = $clog2(`CMD_BYTES);

    ////////////////////////////////////////////////////////////
    // byte assembly

    host_cmd_t        cmd_sr;
    host_cmd_t        next_cmd;
    logic [CNT_W-1:0] byte_cnt;
    logic             last_byte;

    // first byte in ends up in the top of addr
    assign next_cmd  = {cmd_sr[$bits(host_cmd_t)-9:0], cmd_byte_i};
    assign last_byte = cmd_byte_valid_i && (byte_cnt == CNT_W'(`CMD_BYTES - 1));

    always_ff @(posedge core_clk) begin
        if (cmd_byte_valid_i) begin
            cmd_sr <= next_cmd;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            byte_cnt <= '0;
        end else if (cmd_byte_valid_i) begin
            byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // corner registers

    logic col_ok;
    logic row_ok;

    // a corner that would push the window off the frame is refused
    assign col_ok = next_cmd.data <= 32'(`RAW_WIDTH - `CROP_WIDTH);
    assign row_ok = next_cmd.data <= 32'(`RAW_HEIGHT - `CROP_HEIGHT);

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            corner_o.col <= POS_W'(`DEFAULT_COL_CORNER);
            corner_o.row <= POS_W'(`DEFAULT_ROW_CORNER);
        end else if (last_byte) begin
            if (next_cmd.addr == `ADDR_COL_CORNER && col_ok) begin
                corner_o.col <= next_cmd.data[POS_W-1:0];
            end
            if (next_cmd.addr == `ADDR_ROW_CORNER && row_ok) begin
                corner_o.row <= next_cmd.data[POS_W-1:0];
            end
        end
    end

endmodule

/* hw/pixel_fifo.sv */
`timescale 1ns/10ps
`include "preview_consts.svh"

module pixel_fifo (
    input  logic                     core_clk,
    input  logic                     sys_reset,
    input  logic                     push_i,
    input  stream_pkg::pixel_beat_t  beat_i,
    input  logic                     pop_i,
    output stream_pkg::pixel_beat_t  head_o,
    output logic                     not_empty_o,
    output logic                     overflow_o
);
    import stream_pkg::*;

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    pixel_beat_t      mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full        = count == (PTR_W + 1)'(DEPTH);
    assign not_empty_o = count != '0;
    assign do_push     = push_i && !full;
    assign do_pop      = pop_i && not_empty_o;

    // fall-through read, head is valid whenever not empty
    assign head_o = mem[rd_ptr];

    always_ff @(posedge core_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= beat_i;
        end
    end

    always_ff @(posedge core_clk) begin
        if (sys_reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // sticky until reset, dropped pixels break the frame
            if (push_i && full) begin
                overflow_o <= 1'b1;
            end
        end
    end

endmodule

/* hw/preview_top.sv */
`timescale 1ns/10ps

module preview_top (
    input  logic                     core_clk,
    input  logic                     sys_reset,

    // camera pixel stream
    input  stream_pkg::pixel_beat_t  pixel_i,
    input  logic                     pixel_valid_i,

    // host command bytes
    input  logic [7:0]               cmd_byte_i,
    input  logic                     cmd_byte_valid_i,

    // host byte link
    output logic [7:0]               out_byte_o,
    output logic                     out_valid_o,
    input  logic                     stall_i,

    output logic                     overflow_o
);
    import stream_pkg::*;
    import cmd_pkg::*;

    ////////////////////////////////////////////////////////////
    // input side

    placed_beat_t placed;
    logic         placed_valid;
    roi_corner_t  corner;

    frame_position_counter u_position (
        .core_clk       (core_clk),
        .sys_reset      (sys_reset),
        .pixel_i        (pixel_i),
        .pixel_valid_i  (pixel_valid_i),
        .placed_o       (placed),
        .placed_valid_o (placed_valid)
    );

    host_command_port u_cmd_port (
        .core_clk         (core_clk),
        .sys_reset        (sys_reset),
        .cmd_byte_i       (cmd_byte_i),
        .cmd_byte_valid_i (cmd_byte_valid_i),
        .corner_o         (corner)
    );

    ////////////////////////////////////////////////////////////
    // crop, buffer and serialize

    logic        push;
    pixel_beat_t cropped;
    pixel_beat_t head;
    logic        not_empty;
    logic        pop;

    crop_window u_crop (
        .core_clk       (core_clk),
        .sys_reset      (sys_reset),
        .placed_i       (placed),
        .placed_valid_i (placed_valid),
        .corner_i       (corner),
        .push_o         (push),
        .beat_o         (cropped)
    );

    pixel_fifo u_fifo (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .push_i      (push),
        .beat_i      (cropped),
        .pop_i       (pop),
        .head_o      (head),
        .not_empty_o (not_empty),
        .overflow_o  (overflow_o)
    );

    frame_serializer u_serializer (
        .core_clk    (core_clk),
        .sys_reset   (sys_reset),
        .head_i      (head),
        .not_empty_i (not_empty),
        .pop_o       (pop),
        .stall_i     (stall_i),
        .out_byte_o  (out_byte_o),
        .out_valid_o (out_valid_o)
    );

endmodule

/* hw/stream_pkg.sv */
`include "preview_consts.svh"

package stream_pkg;

    typedef logic [7:0] pixel_t;

    // one pixel on the stream, sof marks the first of a frame
    typedef struct packed {
        pixel_t data;
        logic   sof;
    } pixel_beat_t;

    typedef struct packed {
        logic [`POS_BITS-1:0] col;
        logic [`POS_BITS-1:0] row;
    } pixel_pos_t;

    // pixel tagged with where it sits in the raw frame
    typedef struct packed {
        pixel_beat_t beat;
        pixel_pos_t  pos;
    } placed_beat_t;

endpackage

/* include/preview_consts.svh */
`ifndef PREVIEW_CONSTS_SVH
`define PREVIEW_CONSTS_SVH

// raw sensor frame
`define RAW_WIDTH           16
`define RAW_HEIGHT          12

// region of interest sent to the host
`define CROP_WIDTH          8
`define CROP_HEIGHT         6

// width of a row or column index
`define POS_BITS            16

// corner used until the host moves it
`define DEFAULT_COL_CORNER  ((`RAW_WIDTH - `CROP_WIDTH) / 2)
`define DEFAULT_ROW_CORNER  ((`RAW_HEIGHT - `CROP_HEIGHT) / 2)

// "BIVFRAME", most significant byte goes out first
`define MAGIC_NUM           64'h42_49_56_46_52_41_4D_45
`define MAGIC_BYTES         8

`define FIFO_DEPTH          64

// host commands are 2 address bytes then 4 data bytes
`define CMD_BYTES           6
`define ADDR_COL_CORNER     16'h0000
`define ADDR_ROW_CORNER     16'h0001

`endif

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

mkdir -p build
verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module preview_tb -Mdir build/obj_dir
./build/obj_dir/Vpreview_tb | tee build/sim.log

if grep -q "^=== PASS ===$" build/sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* src.f */
+incdir+include
hw/stream_pkg.sv
hw/cmd_pkg.sv
hw/frame_position_counter.sv
hw/host_command_port.sv
hw/crop_window.sv
hw/pixel_fifo.sv
hw/frame_serializer.sv
hw/preview_top.sv
bench/tb_clock_gen.sv
bench/preview_properties.sv
bench/preview_tb.sv
